/* compile.f */
+incdir+.
switch_info_pkg.sv
sync_fifo.sv
pu_req_decode.sv
pu_read_arbiter.sv
switch_info_table.sv
pu_resp_router.sv
switch_info_mem_top.sv
tb_clock_gen.sv
tb_switch_info.sv

/* run_sim.sh */
#!/bin/sh
# Builds the switch-info testbench with Verilator, runs it into sim.log and reports the result

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_switch_info -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
exit 0

/* tb_switch_info.sv */
// Table-driven testbench for the switch-info lookup, run as the simulation top with compile.f
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module tb_switch_info;

	import switch_info_pkg::*;

	localparam int CLK_PERIOD_NS = 4;
	localparam int NUM_ROWS      = 21;
	localparam int WATCHDOG_NS   = NUM_ROWS * 40 * CLK_PERIOD_NS;
	localparam int ACK_WAIT      = 30;  // Cycles allowed for a burst to be answered
	localparam int QUIET_CYCLES  = 10;
	localparam logic [`SI_REGION_W-1:0] RGN = `SI_REGION_W'(`SI_REGION_SWITCH_INFO);

	typedef enum logic [2:0] {OP_IDLE, OP_WR, OP_RD, OP_PU, OP_MIX} op_t;

	// OP_MIX writes index {~fid, ofs} over APB while the masked PUs read
	typedef struct packed {
		op_t                     op;
		logic [`SI_NUM_PU-1:0]   mask;
		logic [`SI_FID_W-1:0]    fid;
		logic [`SI_OFS_W-1:0]    ofs;
		logic [`SI_REGION_W-1:0] region;
	} stim_row_t;

	typedef struct packed {
		pu_id_t                pu;
		logic [`SI_DATA_W-1:0] data;
		logic [31:0]           edge_no;
	} ack_rec_t;

	logic                  clk;
	logic                  rst_n;
	apb_req_t              apb_req;
	apb_resp_t             apb_resp;
	logic [`SI_NUM_PU-1:0] io_req;
	pu_cmd_t               io_cmd [`SI_NUM_PU];
	logic [`SI_NUM_PU-1:0] req_ready;
	pu_resp_t              io_resp [`SI_NUM_PU];

	stim_row_t             rows [NUM_ROWS];
	logic [`SI_DATA_W-1:0] ref_mem [1 << `SI_ADDR_W]; // Mirror of every APB write
	ack_rec_t              ack_q [$];
	logic [31:0]           edge_cnt = '0;
	integer                seed;
	int                    rr_ptr;                    // Expected round-robin pointer

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk));

	switch_info_mem_top uut (
		.clk (clk), .rst_n (rst_n), .apb_req (apb_req), .apb_resp (apb_resp),
		.io_req (io_req), .io_cmd (io_cmd), .req_ready (req_ready), .io_resp (io_resp)
	);

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH time %0t: %s is %h, expected %h", $time, name, actual, expected);
			abort_run("a checked value differs from its expected value");
		end
	endtask

	// Records every ack once outputs have settled after the falling edge
	always begin : ack_monitor
		ack_rec_t rec;
		int       seen;
		@(negedge clk);
		#1;
		seen = 0;
		for (int i = 0; i < `SI_NUM_PU; i++) begin
			if (io_resp[i].ack === 1'b1) begin
				rec.pu      = pu_id_t'(i);
				rec.data    = io_resp[i].data;
				rec.edge_no = edge_cnt;
				ack_q.push_back(rec);
				seen++;
			end
		end
		if (seen > 1)
			abort_run("more than one PU was acknowledged in the same cycle");
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("timeout: the test sequence did not finish within the time limit");
	end

	task automatic write_table(input logic [`SI_ADDR_W-1:0] addr,
		input logic [`SI_DATA_W-1:0] data);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		check("pready in write access", 32'(apb_resp.pready), 32'd1); // No wait state on writes
		check("pslverr in write access", 32'(apb_resp.pslverr), 32'd0);
		ref_mem[addr] = data;
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic read_table(input logic [`SI_ADDR_W-1:0] addr);
		@(negedge clk);
		apb_req.psel   = 1'b1;
		apb_req.pwrite = 1'b0;
		apb_req.paddr  = addr;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		check("pready in first read access", 32'(apb_resp.pready), 32'd0);
		@(negedge clk);
		#1;
		check("pready in second read access", 32'(apb_resp.pready), 32'd1);
		check("pslverr in read access", 32'(apb_resp.pslverr), 32'd0);
		check("prdata", apb_resp.prdata, ref_mem[addr]);
		@(negedge clk);
		apb_req = '0;
	endtask

	// PU i asks for offset ofs + i, so each PU reads its own index
	task automatic drive_pu(input stim_row_t row, output logic [31:0] e0);
		@(negedge clk);
		e0     = edge_cnt;
		io_req = row.mask;
		for (int i = 0; i < `SI_NUM_PU; i++) begin
			io_cmd[i].region = row.region;
			io_cmd[i].fid    = row.fid;
			io_cmd[i].offset = row.ofs + `SI_OFS_W'(i);
		end
		#1;
		check("req_ready", 32'(req_ready & row.mask), 32'(row.mask));
		@(negedge clk);
		io_req = '0;
	endtask

	task automatic run_pu_burst(input stim_row_t row, input bit with_write);
		pu_id_t                exp_pu [$];
		logic [`SI_DATA_W-1:0] exp_data [$];
		logic [`SI_ADDR_W-1:0] idx;
		logic [31:0]           e0;
		pu_id_t                p;
		int                    n;
		int                    wait_cycles;
		if (row.region == RGN) begin
			for (int k = 0; k < `SI_NUM_PU; k++) begin
				p = pu_id_t'((rr_ptr + k) % `SI_NUM_PU); // Grant order starts at the pointer
				if (row.mask[p]) begin
					idx = {row.fid, row.ofs + `SI_OFS_W'(p)};
					exp_pu.push_back(p);
					exp_data.push_back(ref_mem[idx]);
				end
			end
			if (exp_pu.size() > 0)
				rr_ptr = (int'(exp_pu[$]) + 1) % `SI_NUM_PU;
		end
		if (with_write) begin
			fork
				write_table({~row.fid, row.ofs}, $random(seed));
				drive_pu(row, e0);
			join
		end else begin
			drive_pu(row, e0);
		end
		n = exp_pu.size();
		wait_cycles = (n == 0) ? QUIET_CYCLES : ACK_WAIT;
		for (int c = 0; c < wait_cycles; c++) begin
			@(negedge clk);
			if (n > 0 && ack_q.size() >= n)
				break;
		end
		if (ack_q.size() < n)
			abort_run($sformatf("timeout: %0d of %0d PU acks arrived", ack_q.size(), n));
		repeat (4) @(negedge clk); // Extra acks would show up here
		check("number of PU acks", 32'(ack_q.size()), 32'(n));
		for (int j = 0; j < n; j++) begin
			check("acknowledged PU", 32'(ack_q[j].pu), 32'(exp_pu[j]));
			check($sformatf("io_resp[%0d].data", exp_pu[j]), ack_q[j].data, exp_data[j]);
			if (n == 1 && !with_write)
				check("ack edges counting the accepting edge", ack_q[j].edge_no - e0, 32'd3);
		end
		ack_q.delete();
	endtask

	task automatic apply_row(input stim_row_t row);
		case (row.op)
			OP_WR:   write_table({row.fid, row.ofs}, $random(seed));
			OP_RD:   read_table({row.fid, row.ofs});
			OP_PU:   run_pu_burst(row, 1'b0);
			OP_MIX:  run_pu_burst(row, 1'b1);
			default: repeat (4) @(negedge clk);
		endcase
		check("acks outside a PU burst", 32'(ack_q.size()), 32'd0);
	endtask

	task automatic load_table();
		rows[0]  = '{OP_WR,   4'b0000, 4'h1, 4'h0, RGN};
		rows[1]  = '{OP_WR,   4'b0000, 4'h1, 4'h1, RGN};
		rows[2]  = '{OP_WR,   4'b0000, 4'h1, 4'h2, RGN};
		rows[3]  = '{OP_WR,   4'b0000, 4'h1, 4'h3, RGN};
		rows[4]  = '{OP_WR,   4'b0000, 4'h7, 4'h8, RGN};
		rows[5]  = '{OP_WR,   4'b0000, 4'h7, 4'hA, RGN};
		rows[6]  = '{OP_WR,   4'b0000, 4'hC, 4'h5, RGN};
		rows[7]  = '{OP_RD,   4'b0000, 4'h1, 4'h0, RGN};
		rows[8]  = '{OP_RD,   4'b0000, 4'h1, 4'h3, RGN};
		rows[9]  = '{OP_RD,   4'b0000, 4'h7, 4'h8, RGN};
		rows[10] = '{OP_RD,   4'b0000, 4'hC, 4'h5, RGN};
		rows[11] = '{OP_PU,   4'b1111, 4'h1, 4'h0, RGN};  // First PU traffic with the pointer at PU 0
		rows[12] = '{OP_PU,   4'b0100, 4'hC, 4'h3, RGN};
		rows[13] = '{OP_PU,   4'b0001, 4'h7, 4'h8, RGN};
		rows[14] = '{OP_PU,   4'b0010, 4'h1, 4'h0, 4'd5}; // Wrong region is never answered
		rows[15] = '{OP_IDLE, 4'b0000, 4'h0, 4'h0, RGN};
		rows[16] = '{OP_MIX,  4'b1111, 4'h1, 4'h0, RGN};
		rows[17] = '{OP_MIX,  4'b0101, 4'h7, 4'h8, RGN};
		rows[18] = '{OP_RD,   4'b0000, 4'hE, 4'h0, RGN};
		rows[19] = '{OP_RD,   4'b0000, 4'h8, 4'h8, RGN};
		rows[20] = '{OP_PU,   4'b1010, 4'h1, 4'h0, RGN};
	endtask

	initial begin : main_seq
		seed    = 32'h1777_ddc1;
		rr_ptr  = 0;
		rst_n   = 1'b0;
		apb_req = '0;
		io_req  = '0;
		for (int i = 0; i < `SI_NUM_PU; i++)
			io_cmd[i] = '0;
		load_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		for (int i = 0; i < `SI_NUM_PU; i++)
			check($sformatf("io_resp[%0d].ack after reset", i), 32'(io_resp[i].ack), 32'd0);
		check("pready after reset", 32'(apb_resp.pready), 32'd0);
		check("req_ready after reset", 32'(req_ready), 32'(4'b1111));
		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(rows[r]);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
// Free-running testbench clock, instantiated by the switch-info testbench
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk; // Starts low, first rising edge at half a period
	end

endmodule

/* switch_info_mem_top.sv */
// Top level of the shared switch-info lookup, connecting decode, arbiter, table and router
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module switch_info_mem_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  switch_info_pkg::apb_req_t  apb_req,
	output switch_info_pkg::apb_resp_t apb_resp,
	input  logic [`SI_NUM_PU-1:0]      io_req,
	input  switch_info_pkg::pu_cmd_t   io_cmd [`SI_NUM_PU],
	output logic [`SI_NUM_PU-1:0]      req_ready,
	output switch_info_pkg::pu_resp_t  io_resp [`SI_NUM_PU]
);

	import switch_info_pkg::*;

	logic [`SI_NUM_PU-1:0] pending;
	logic [`SI_NUM_PU-1:0] pop;
	pu_cmd_t               head_cmd [`SI_NUM_PU];
	logic                  port_busy;
	logic                  rd_en;
	logic [`SI_ADDR_W-1:0] rd_addr;
	pu_id_t                grant_id;
	logic                  rd_valid;
	logic [`SI_DATA_W-1:0] rd_data;

	pu_req_decode u_decode (
		.clk (clk), .rst_n (rst_n), .io_req (io_req), .io_cmd (io_cmd),
		.req_ready (req_ready), .pending (pending), .head_cmd (head_cmd), .pop (pop)
	);

	pu_read_arbiter u_arbiter (
		.clk (clk), .rst_n (rst_n), .pending (pending), .head_cmd (head_cmd),
		.port_busy (port_busy), .pop (pop), .rd_en (rd_en), .rd_addr (rd_addr),
		.grant_id (grant_id)
	);

	switch_info_table u_table (
		.clk (clk), .rst_n (rst_n), .apb_req (apb_req), .apb_resp (apb_resp),
		.rd_en (rd_en), .rd_addr (rd_addr), .rd_valid (rd_valid), .rd_data (rd_data),
		.port_busy (port_busy)
	);

	pu_resp_router u_router (
		.clk (clk), .rst_n (rst_n), .grant (rd_en), .grant_id (grant_id),
		.rd_valid (rd_valid), .rd_data (rd_data), .io_resp (io_resp)
	);

endmodule

/* pu_resp_router.sv */
// Result stage that tags each table read with its PU and returns the word to that PU
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module pu_resp_router (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     grant,
	input  switch_info_pkg::pu_id_t  grant_id,
	input  logic                     rd_valid,
	input  logic [`SI_DATA_W-1:0]    rd_data,
	output switch_info_pkg::pu_resp_t io_resp [`SI_NUM_PU]
);

	import switch_info_pkg::*;

	pu_id_t tag_head; // Owner of the read now returning

	// Reads return in grant order, so a FIFO of ids is enough
	sync_fifo #(
		.payload_t (pu_id_t),
		.DEPTH     (`SI_TAG_DEPTH)
	) u_tag_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (grant),
		.din   (grant_id),
		.rd    (rd_valid),
		.dout  (tag_head),
		.full  (),
		.empty ()
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `SI_NUM_PU; i++)
				io_resp[i] <= '0;
		end else begin
			for (int i = 0; i < `SI_NUM_PU; i++) begin
				io_resp[i].ack  <= rd_valid && (tag_head == pu_id_t'(i));
				io_resp[i].data <= (rd_valid && (tag_head == pu_id_t'(i))) ? rd_data : '0;
			end
		end
	end

endmodule

/* switch_info_table.sv */
// Single-port switch-info storage shared by the APB host port and the arbitrated PU read port
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module switch_info_table (
	input  logic                       clk,
	input  logic                       rst_n,
	input  switch_info_pkg::apb_req_t  apb_req,
	output switch_info_pkg::apb_resp_t apb_resp,
	input  logic                       rd_en,
	input  logic [`SI_ADDR_W-1:0]      rd_addr,
	output logic                       rd_valid,
	output logic [`SI_DATA_W-1:0]      rd_data,
	output logic                       port_busy
);

	localparam int WORDS = 1 << `SI_ADDR_W;

	logic [`SI_DATA_W-1:0] mem [WORDS];
	logic [`SI_DATA_W-1:0] mem_q;        // Read register shared by both ports
	logic [`SI_ADDR_W-1:0] port_addr;
	logic                  apb_access;
	logic                  apb_wr;
	logic                  apb_rd_first;
	logic                  rd_wait;      // Second cycle of an APB read
	logic                  pu_rd;

	assign apb_access   = apb_req.psel & apb_req.penable;
	assign apb_wr       = apb_access & apb_req.pwrite;
	assign apb_rd_first = apb_access & ~apb_req.pwrite & ~rd_wait;
	assign port_busy    = apb_access;
	assign pu_rd        = rd_en & ~apb_access;
	assign port_addr    = apb_access ? apb_req.paddr : rd_addr;

	// One address into the array per cycle
	always_ff @(posedge clk) begin
		if (apb_wr)
			mem[apb_req.paddr] <= apb_req.pwdata;
		if (apb_rd_first || pu_rd)
			mem_q <= mem[port_addr];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_wait  <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_wait  <= apb_rd_first; // Clears itself after the wait state
			rd_valid <= pu_rd;
		end
	end

	assign rd_data = mem_q;

	// Writes finish at once, reads after one wait state
	always_comb begin
		apb_resp.pready  = apb_access & (apb_req.pwrite | rd_wait);
		apb_resp.prdata  = mem_q;
		apb_resp.pslverr = 1'b0;
	end

endmodule

/* pu_read_arbiter.sv */
// Execute stage that grants one pending PU per free cycle in round-robin order and reads the table
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module pu_read_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`SI_NUM_PU-1:0]    pending,
	input  switch_info_pkg::pu_cmd_t head_cmd [`SI_NUM_PU],
	input  logic                     port_busy,
	output logic [`SI_NUM_PU-1:0]    pop,
	output logic                     rd_en,
	output logic [`SI_ADDR_W-1:0]    rd_addr,
	output switch_info_pkg::pu_id_t  grant_id
);

	import switch_info_pkg::*;

	pu_id_t ptr;       // PU with the highest priority this cycle
	pu_id_t cand;
	pu_id_t sel;
	logic   found;

	// Search starts at the pointer and wraps around
	always_comb begin
		found = 1'b0;
		sel   = ptr;
		cand  = ptr;
		for (int k = 0; k < `SI_NUM_PU; k++) begin
			cand = pu_id_t'((int'(ptr) + k) % `SI_NUM_PU);
			if (!found && pending[cand]) begin
				found = 1'b1;
				sel   = cand;
			end
		end
	end

	assign rd_en    = found & ~port_busy; // APB owns the port while busy
	assign grant_id = sel;
	assign rd_addr  = {head_cmd[sel].fid, head_cmd[sel].offset};

	always_comb begin
		pop = '0;
		if (rd_en)
			pop[sel] = 1'b1;
	end

	// Priority moves to the PU after the granted one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (rd_en) begin
			if (sel == pu_id_t'(`SI_NUM_PU - 1))
				ptr <= '0;
			else
				ptr <= sel + 1'b1;
		end
	end

endmodule

/* pu_req_decode.sv */
// Decode stage that filters PU commands by region and queues the accepted ones per PU
`timescale 1ns/1ps
`include "switch_info_cfg.svh"

module pu_req_decode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`SI_NUM_PU-1:0]     io_req,
	input  switch_info_pkg::pu_cmd_t  io_cmd [`SI_NUM_PU],
	output logic [`SI_NUM_PU-1:0]     req_ready,
	output logic [`SI_NUM_PU-1:0]     pending,
	output switch_info_pkg::pu_cmd_t  head_cmd [`SI_NUM_PU],
	input  logic [`SI_NUM_PU-1:0]     pop
);

	import switch_info_pkg::*;

	logic [`SI_NUM_PU-1:0] q_wr;
	logic [`SI_NUM_PU-1:0] q_full;
	logic [`SI_NUM_PU-1:0] q_empty;

	assign req_ready = ~q_full; // Ready while the queue has room
	assign pending   = ~q_empty;

	// A transferred command with another region is dropped here
	always_comb begin
		for (int i = 0; i < `SI_NUM_PU; i++) begin
			q_wr[i] = io_req[i] & req_ready[i]
				& (io_cmd[i].region == `SI_REGION_W'(`SI_REGION_SWITCH_INFO));
		end
	end

	for (genvar gi = 0; gi < `SI_NUM_PU; gi++) begin : g_cmd_q
		sync_fifo #(
			.payload_t (pu_cmd_t),
			.DEPTH     (`SI_CMD_DEPTH)
		) u_cmd_fifo (
			.clk   (clk),
			.rst_n (rst_n),
			.wr    (q_wr[gi]),
			.din   (io_cmd[gi]),
			.rd    (pop[gi]),
			.dout  (head_cmd[gi]),
			.full  (q_full[gi]),
			.empty (q_empty[gi])
		);
	end

endmodule

/* sync_fifo.sv */
// Register-array FIFO with a typed payload, used for PU command queues and PU-id tag queues
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wr,
	input  payload_t din,
	input  logic     rd,
	output payload_t dout,
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               do_wr;
	logic               do_rd;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;
	assign dout  = mem[rd_ptr]; // Head is visible without a read

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

/* switch_info_pkg.sv */
// Shared struct types for the PU command path, the response path and the APB host port
`include "switch_info_cfg.svh"

package switch_info_pkg;

	// Read command sent by a PU, 12 bits
	typedef struct packed {
		logic [`SI_REGION_W-1:0] region; // Must equal SI_REGION_SWITCH_INFO
		logic [`SI_FID_W-1:0]    fid;
		logic [`SI_OFS_W-1:0]    offset;
	} pu_cmd_t;

	typedef logic [`SI_PU_ID_W-1:0] pu_id_t;

	// Response to one PU, ack is a single-cycle pulse
	typedef struct packed {
		logic                  ack;
		logic [`SI_DATA_W-1:0] data;
	} pu_resp_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [`SI_ADDR_W-1:0] paddr;
		logic [`SI_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic                  pready;
		logic [`SI_DATA_W-1:0] prdata;
		logic                  pslverr;
	} apb_resp_t;

endpackage

/* switch_info_cfg.svh */
// Size and region settings for the switch-info table, included by the package, RTL and testbench
`ifndef SWITCH_INFO_CFG_SVH
`define SWITCH_INFO_CFG_SVH

// PU side
`define SI_NUM_PU             4
`define SI_PU_ID_W            2
`define SI_CMD_DEPTH          2

// Command fields
`define SI_REGION_W           4
`define SI_REGION_SWITCH_INFO 3
`define SI_FID_W              4
`define SI_OFS_W              4

// Table geometry, the index is fid followed by offset
`define SI_DATA_W             32
`define SI_ADDR_W             (`SI_FID_W + `SI_OFS_W)
`define SI_TAG_DEPTH          4

`endif
